/* files.f */
verilog/iic_bus_pkg.sv
verilog/iic_cmd_pkg.sv
verilog/iic_cmd_latch.sv
verilog/iic_sequencer.sv
verilog/iic_line_driver.sv
verilog/iic_master.sv
tests/iic_slave_model.sv
tests/tb_iic_master.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the I2C master testbench with Verilator.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_iic_master \
    -f files.f \
    -o sim_tb_iic_master

# the simulation's own exit status is judged through the log
./obj_dir/sim_tb_iic_master 2>&1 | tee "$LOG"

if grep -q "Simulation finished: PASS" "$LOG"; then
    echo "run_sim: pass"
    exit 0
else
    echo "run_sim: fail"
    exit 1
fi

/* tests/iic_slave_model.sv */
`timescale 1ns/1ps

module iic_slave_model (
    input  logic       scl,
    inout  wire        sda,
    input  logic       wide,      // address mode of the current command
    output logic [7:0] last_dev,
    output logic [7:0] addr_hi,
    output logic [7:0] addr_lo,
    output logic [7:0] wr_byte,
    output int         start_cnt,
    output int         stop_cnt
);

    logic [7:0] mem [0:65535];
    logic       drv_en = 1'b0;
    logic       drv_en_d;
    logic       drv_val = 1'b1;
    logic       prev_scl = 1'b1;
    logic       prev_sda = 1'b1;
    logic [7:0] shift = '0;
    logic [7:0] tx = '0;
    int         bit_cnt = 0;
    int         byte_idx = 0;
    logic       ack_slot = 1'b0;
    logic       reading = 1'b0;
    logic       send_next = 1'b0;

    // drive starts late so the master has let go of the line
    assign #6 drv_en_d = drv_en;
    assign sda = (drv_en && drv_en_d) ? drv_val : 1'bz;

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i[7:0] ^ i[15:8] ^ 8'h5a;
        end
        last_dev = '0;
        addr_hi = '0;
        addr_lo = '0;
        wr_byte = '0;
        start_cnt = 0;
        stop_cnt = 0;
    end

    task automatic take_byte(input logic [7:0] b);
        case (byte_idx)
            0: begin
                last_dev = b;
                send_next = b[0];
                if (!b[0] && !wide) begin
                    addr_hi = '0;
                end
            end
            1: begin
                if (wide) addr_hi = b;
                else addr_lo = b;
            end
            default: begin
                if (wide && byte_idx == 2) begin
                    addr_lo = b;
                end else begin
                    wr_byte = b;
                    mem[{addr_hi, addr_lo}] = b;
                end
            end
        endcase
        byte_idx++;
    endtask

    always @(scl or sda) begin
        if (scl && prev_scl && prev_sda === 1'b1 && sda === 1'b0) begin
            start_cnt++;  // start or repeated start
            byte_idx = 0;
            bit_cnt = 0;
            ack_slot = 1'b0;
            reading = 1'b0;
            send_next = 1'b0;
            drv_en = 1'b0;
        end else if (scl && prev_scl && prev_sda === 1'b0 && sda === 1'b1) begin
            stop_cnt++;
            bit_cnt = 0;
            ack_slot = 1'b0;
            reading = 1'b0;
            drv_en = 1'b0;
        end else if (scl && !prev_scl) begin
            if (bit_cnt < 8) begin
                if (!reading) shift = {shift[6:0], sda};
                bit_cnt++;
            end else begin
                bit_cnt = 0;  // ack clock
            end
        end else if (!scl && prev_scl) begin
            if (bit_cnt == 8 && !ack_slot) begin
                ack_slot = 1'b1;
                if (reading) begin
                    drv_en = 1'b0;  // master answers with nack
                end else begin
                    take_byte(shift);
                    drv_val = 1'b0;
                    drv_en = 1'b1;
                end
            end else if (ack_slot && bit_cnt == 0) begin
                ack_slot = 1'b0;
                if (send_next) begin
                    send_next = 1'b0;
                    reading = 1'b1;
                    tx = mem[{addr_hi, addr_lo}];
                    drv_val = tx[7];
                end else begin
                    reading = 1'b0;
                    drv_en = 1'b0;
                end
            end else if (reading && bit_cnt > 0 && bit_cnt < 8) begin
                drv_val = tx[7 - bit_cnt];
            end
        end
        prev_scl = scl;
        prev_sda = sda;
    end

endmodule

/* tests/tb_iic_master.sv */
`timescale 1ns/1ps

module tb_iic_master;

    import iic_bus_pkg::*;
    import iic_cmd_pkg::*;

    localparam int N_RANDOM = 40;
    localparam int N_OPS    = N_RANDOM + 4;
    localparam int LIMIT    = N_OPS * 205 + 200;

    logic       dri_clk;
    logic       rst_n;
    logic       iic_exec;
    iic_cmd_t   iic_cmd;
    byte_t      iic_data_r;
    logic       iic_done;
    logic       scl;
    wire        sda;
    logic       slave_wide;
    logic [7:0] last_dev, addr_hi, addr_lo, wr_byte;
    int         start_cnt, stop_cnt;
    int         cycle_cnt = 0;
    int         seed = 32'hcc69_5e98;
    logic [7:0] shadow [0:65535];
    logic       written [0:65535];

    iic_master i_iic_master (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .iic_exec   (iic_exec),
        .iic_cmd    (iic_cmd),
        .iic_data_r (iic_data_r),
        .iic_done   (iic_done),
        .scl        (scl),
        .sda        (sda)
    );

    iic_slave_model i_slave_model (
        .scl       (scl),
        .sda       (sda),
        .wide      (slave_wide),
        .last_dev  (last_dev),
        .addr_hi   (addr_hi),
        .addr_lo   (addr_lo),
        .wr_byte   (wr_byte),
        .start_cnt (start_cnt),
        .stop_cnt  (stop_cnt)
    );

    initial begin
        dri_clk = 1'b0;
        forever #2 dri_clk = ~dri_clk;
    end

    always @(posedge dri_clk) begin
        cycle_cnt++;
        if (cycle_cnt > LIMIT) begin
            $display("timeout: the run took more than %0d cycles", LIMIT);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

    // expected read byte from the shadow or the slave's power-up fill
    function automatic logic [7:0] ref_read(input logic [15:0] a);
        if (written[a]) return shadow[a];
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic run_op(input logic rd, input logic wide, input logic [15:0] addr,
                          input logic [7:0] data);
        int         starts0;
        int         stops0;
        int         cycles;
        logic [15:0] a_eff;
        a_eff = wide ? addr : {8'h00, addr[7:0]};
        starts0 = start_cnt;
        stops0 = stop_cnt;
        cycles = 0;
        @(negedge dri_clk);
        slave_wide = wide;
        iic_cmd = '{rh_wl: rd, bit_ctrl: wide, addr: addr, data_w: data};
        iic_exec = 1'b1;  // held high until done
        do begin
            @(negedge dri_clk);
            cycles++;
        end while (!iic_done);
        iic_exec = 1'b0;
        // done edge count plus the half cycle to this negedge
        check("cycles to done", cycles, 130 + (wide ? 36 : 0) + (rd ? 40 : 0));
        check("start count", start_cnt - starts0, rd ? 2 : 1);
        check("stop count", stop_cnt - stops0, 1);
        check("addr_lo", 32'(addr_lo), 32'(addr[7:0]));
        if (wide) check("addr_hi", 32'(addr_hi), 32'(addr[15:8]));
        if (rd) begin
            check("device byte", 32'(last_dev), 32'h0000_00a1);  // 1010000 then read
            check("iic_data_r", 32'(iic_data_r), 32'(ref_read(a_eff)));
        end else begin
            check("device byte", 32'(last_dev), 32'h0000_00a0);  // 1010000 then write
            check("wr_byte", 32'(wr_byte), 32'(data));
            check("slave memory", 32'(i_slave_model.mem[a_eff]), 32'(data));
            shadow[a_eff] = data;
            written[a_eff] = 1'b1;
        end
        @(negedge dri_clk);
        check("iic_done width", 32'(iic_done), 0);
    endtask

    initial begin
        logic       rd;
        logic       wide;
        logic [15:0] addr;
        logic [7:0] data;
        rst_n = 1'b0;
        iic_exec = 1'b0;
        iic_cmd = '0;
        slave_wide = 1'b0;
        for (int i = 0; i < 65536; i++) written[i] = 1'b0;
        repeat (5) @(negedge dri_clk);
        rst_n = 1'b1;
        @(negedge dri_clk);
        check("scl", 32'(scl), 1);
        check("sda", 32'(sda), 1);
        check("iic_done", 32'(iic_done), 0);
        check("iic_data_r", 32'(iic_data_r), 0);
        run_op(1'b0, 1'b0, 16'h0005, 8'ha5);
        run_op(1'b0, 1'b1, 16'h0107, 8'h3c);
        run_op(1'b1, 1'b0, 16'h0005, 8'h00);
        run_op(1'b1, 1'b1, 16'h0107, 8'h00);
        for (int n = 0; n < N_RANDOM; n++) begin
            rd = 1'($random(seed));
            wide = 1'($random(seed));
            addr = {7'h00, 1'($random(seed)), 4'h0, 4'($random(seed))};
            data = 8'($random(seed));
            run_op(rd, wide, addr, data);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* verilog/iic_bus_pkg.sv */
package iic_bus_pkg;

    typedef logic [7:0]  byte_t;       // one byte on the wire
    typedef logic [15:0] word_addr_t;  // eeprom word address
    typedef logic [6:0]  dev_addr_t;   // 7-bit slave address
    typedef logic [6:0]  step_t;       // step count inside a phase

    localparam dev_addr_t SLAVE_ADDR = 7'b1010000;

    // a bit takes four steps
    // data moves on step 4k, scl rises on 4k+1 and falls on 4k+3
    localparam step_t STEPS_PER_BIT = 7'd4;

    // start slot + 8 bits + ack slot
    localparam step_t LAST_STEP_START = 7'd39;

    // 8 bits + ack slot
    localparam step_t LAST_STEP_BYTE = 7'd35;

    // stop condition, then the bus idles high until done
    localparam step_t LAST_STEP_STOP = 7'd16;

    // step_done is registered, so it is raised one step early
    localparam step_t DONE_STEP_START = LAST_STEP_START - 7'd1;
    localparam step_t DONE_STEP_BYTE  = LAST_STEP_BYTE - 7'd1;
    localparam step_t DONE_STEP_STOP  = LAST_STEP_STOP - 7'd1;

endpackage

/* verilog/iic_cmd_latch.sv */
`timescale 1ns/1ps

module iic_cmd_latch (
    input  logic                   dri_clk,
    input  logic                   rst_n,
    input  logic                   iic_exec,
    input  iic_cmd_pkg::iic_cmd_t  iic_cmd,
    input  iic_cmd_pkg::iic_step_t cur,
    output logic [1:0]             cmd_mode,
    output iic_bus_pkg::byte_t     tx_byte
);

    import iic_bus_pkg::*;
    import iic_cmd_pkg::*;

    iic_cmd_t cmd_q;

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_q <= '0;
        end else if (cur.phase == PH_IDLE && iic_exec) begin
            cmd_q <= iic_cmd;  // same edge the sequencer leaves idle
        end
    end

    assign cmd_mode = {cmd_q.rh_wl, cmd_q.bit_ctrl};

    always_comb begin
        case (cur.phase)
            PH_SLADDR:  tx_byte = {SLAVE_ADDR, 1'b0};
            PH_ADDR_HI: tx_byte = cmd_q.addr[15:8];
            PH_ADDR_LO: tx_byte = cmd_q.addr[7:0];
            PH_DATA_WR: tx_byte = cmd_q.data_w;
            PH_ADDR_RD: tx_byte = {SLAVE_ADDR, 1'b1};
            default:    tx_byte = '1;  // nothing to send
        endcase
    end

    // a new command shows up only as the sequencer leaves idle
    a_cmd_hold: assert property (@(posedge dri_clk) disable iff (!rst_n)
        !$stable(cmd_q) |-> cur.phase == PH_SLADDR);

endmodule

/* verilog/iic_cmd_pkg.sv */
package iic_cmd_pkg;

    import iic_bus_pkg::*;

    typedef struct packed {
        logic       rh_wl;     // 1 = read
        logic       bit_ctrl;  // 1 = 16-bit word address
        word_addr_t addr;
        byte_t      data_w;
    } iic_cmd_t;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_SLADDR,   // start + device byte, write
        PH_ADDR_HI,
        PH_ADDR_LO,
        PH_DATA_WR,
        PH_ADDR_RD,  // repeated start + device byte, read
        PH_DATA_RD,
        PH_STOP
    } iic_phase_e;

    typedef struct packed {
        iic_phase_e phase;
        step_t      step;
    } iic_step_t;

endpackage

/* verilog/iic_line_driver.sv */
`timescale 1ns/1ps

module iic_line_driver (
    input  logic                   dri_clk,
    input  logic                   rst_n,
    input  iic_cmd_pkg::iic_step_t cur,
    input  iic_bus_pkg::byte_t     tx_byte,
    input  logic                   sda_in,
    output logic                   scl,
    output logic                   sda_out,
    output logic                   sda_oe,
    output logic                   step_done,
    output logic                   iic_done,
    output iic_bus_pkg::byte_t     iic_data_r
);

    import iic_bus_pkg::*;
    import iic_cmd_pkg::*;

    logic  start_ph;   // phase opens with a start or repeated start
    logic  stop_ph;
    logic  read_ph;
    step_t slot;       // bit slot within the phase
    step_t pos;        // step within the slot
    step_t bit_idx;    // 0..7 data, 8 ack
    step_t done_step;
    logic  start_slot;
    logic  cond_step;  // sda may move under high scl here
    byte_t rx_shift;

    assign start_ph   = (cur.phase == PH_SLADDR) || (cur.phase == PH_ADDR_RD);
    assign stop_ph    = cur.phase == PH_STOP;
    assign read_ph    = cur.phase == PH_DATA_RD;
    assign slot       = cur.step / STEPS_PER_BIT;
    assign pos        = cur.step % STEPS_PER_BIT;
    assign bit_idx    = start_ph ? slot - 1'b1 : slot;
    assign start_slot = start_ph && slot == '0;
    assign done_step  = start_ph ? DONE_STEP_START :
                        stop_ph  ? DONE_STEP_STOP  : DONE_STEP_BYTE;
    assign cond_step  = (start_slot && pos == 7'd2) || (stop_ph && cur.step == 7'd3);

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            scl        <= 1'b1;
            sda_out    <= 1'b1;
            sda_oe     <= 1'b1;
            step_done  <= 1'b0;
            iic_done   <= 1'b0;
            iic_data_r <= '0;
        end else begin
            step_done <= (cur.phase != PH_IDLE) && (cur.step == done_step);
            iic_done  <= stop_ph && (cur.step == LAST_STEP_STOP);
            if (cur.phase == PH_IDLE) begin
                scl     <= 1'b1;  // bus idle, both lines high
                sda_out <= 1'b1;
                sda_oe  <= 1'b1;
            end else if (stop_ph) begin
                if (cur.step == '0) begin
                    sda_oe  <= 1'b1;
                    sda_out <= 1'b0;
                end
                if (cur.step == 7'd1) begin
                    scl <= 1'b1;
                end
                if (cur.step == 7'd3) begin
                    sda_out <= 1'b1;  // stop
                end
            end else begin
                if (pos == 7'd1) begin
                    scl <= 1'b1;
                end
                if (pos == 7'd3) begin
                    scl <= 1'b0;
                end
                if (pos == '0) begin
                    if (start_slot) begin
                        sda_oe  <= 1'b1;
                        sda_out <= 1'b1;
                    end else if (bit_idx < 7'd8) begin
                        sda_oe <= !read_ph;
                        if (!read_ph) begin
                            sda_out <= tx_byte[3'd7 - bit_idx[2:0]];  // msb first
                        end
                    end else begin
                        sda_oe  <= read_ph;  // nack after read, else release
                        sda_out <= 1'b1;
                    end
                end
                if (start_slot && pos == 7'd2) begin
                    sda_out <= 1'b0;  // start under high scl
                end
                if (read_ph && cur.step == LAST_STEP_BYTE) begin
                    iic_data_r <= rx_shift;
                end
            end
        end
    end

    // read bits taken as scl goes high
    always_ff @(posedge dri_clk) begin
        if (read_ph && pos == 7'd1 && bit_idx < 7'd8) begin
            rx_shift <= {rx_shift[6:0], sda_in};
        end
    end

    a_sda_stable: assert property (@(posedge dri_clk) disable iff (!rst_n)
        (scl && $past(scl) && !$past(cond_step)) |-> sda_out == $past(sda_out));

endmodule

/* verilog/iic_master.sv */
`timescale 1ns/1ps

module iic_master (
    input  logic                  dri_clk,
    input  logic                  rst_n,
    input  logic                  iic_exec,
    input  iic_cmd_pkg::iic_cmd_t iic_cmd,
    output iic_bus_pkg::byte_t    iic_data_r,
    output logic                  iic_done,
    output logic                  scl,
    inout  wire                   sda
);

    import iic_bus_pkg::*;
    import iic_cmd_pkg::*;

    iic_step_t  cur;
    logic [1:0] cmd_mode;  // {rh_wl, bit_ctrl}
    byte_t      tx_byte;
    logic       step_done;
    logic       sda_out;
    logic       sda_oe;
    logic       sda_in;

    assign sda    = sda_oe ? sda_out : 1'bz;  // push-pull when driven
    assign sda_in = sda;

    iic_cmd_latch i_iic_cmd_latch (
        .dri_clk  (dri_clk),
        .rst_n    (rst_n),
        .iic_exec (iic_exec),
        .iic_cmd  (iic_cmd),
        .cur      (cur),
        .cmd_mode (cmd_mode),
        .tx_byte  (tx_byte)
    );

    iic_sequencer i_iic_sequencer (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .iic_exec  (iic_exec),
        .step_done (step_done),
        .cmd_mode  (cmd_mode),
        .cur       (cur)
    );

    iic_line_driver i_iic_line_driver (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .cur        (cur),
        .tx_byte    (tx_byte),
        .sda_in     (sda_in),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_oe     (sda_oe),
        .step_done  (step_done),
        .iic_done   (iic_done),
        .iic_data_r (iic_data_r)
    );

endmodule

/* verilog/iic_sequencer.sv */
`timescale 1ns/1ps

module iic_sequencer (
    input  logic                   dri_clk,
    input  logic                   rst_n,
    input  logic                   iic_exec,
    input  logic                   step_done,
    input  logic [1:0]             cmd_mode,
    output iic_cmd_pkg::iic_step_t cur
);

    import iic_bus_pkg::*;
    import iic_cmd_pkg::*;

    iic_phase_e phase_nxt;
    step_t      last_step;
    logic       rd_mode;
    logic       wide_addr;

    assign rd_mode   = cmd_mode[1];
    assign wide_addr = cmd_mode[0];

    always_comb begin
        case (cur.phase)
            PH_IDLE:               last_step = '0;  // counter parks at zero
            PH_SLADDR, PH_ADDR_RD: last_step = LAST_STEP_START;
            PH_STOP:               last_step = LAST_STEP_STOP;
            default:               last_step = LAST_STEP_BYTE;
        endcase
    end

    always_comb begin
        phase_nxt = cur.phase;
        if (cur.phase == PH_IDLE) begin
            if (iic_exec) begin
                phase_nxt = PH_SLADDR;
            end
        end else if (step_done) begin
            case (cur.phase)
                PH_SLADDR:  phase_nxt = wide_addr ? PH_ADDR_HI : PH_ADDR_LO;
                PH_ADDR_HI: phase_nxt = PH_ADDR_LO;
                PH_ADDR_LO: phase_nxt = rd_mode ? PH_ADDR_RD : PH_DATA_WR;
                PH_ADDR_RD: phase_nxt = PH_DATA_RD;
                PH_DATA_WR: phase_nxt = PH_STOP;
                PH_DATA_RD: phase_nxt = PH_STOP;
                default:    phase_nxt = PH_IDLE;
            endcase
        end
    end

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            cur.phase <= PH_IDLE;
            cur.step  <= '0;
        end else begin
            cur.phase <= phase_nxt;
            if (cur.step == last_step) begin
                cur.step <= '0;
            end else begin
                cur.step <= cur.step + 1'b1;
            end
        end
    end

    a_step_range: assert property (@(posedge dri_clk) disable iff (!rst_n)
        cur.step <= last_step);

    // high address byte only for 16-bit commands
    a_hi_mode: assert property (@(posedge dri_clk) disable iff (!rst_n)
        (cur.phase == PH_ADDR_HI && $past(cur.phase) != PH_ADDR_HI) |-> wide_addr);

endmodule
